//--- design/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

  // Data word on the load/store path
  typedef logic [31:0] word_t;

  // Access size and sign field from the instruction
  typedef logic [2:0] funct3_t;

  // Load codes
  localparam funct3_t FUNCT3_LB  = 3'd0;
  localparam funct3_t FUNCT3_LH  = 3'd1;
  localparam funct3_t FUNCT3_LW  = 3'd2;
  // Unsigned loads share the size bits with LB and LH
  localparam funct3_t FUNCT3_LBU = 3'd4;
  localparam funct3_t FUNCT3_LHU = 3'd5;

  // Store codes
  localparam funct3_t FUNCT3_SB  = 3'd0;
  localparam funct3_t FUNCT3_SH  = 3'd1;
  localparam funct3_t FUNCT3_SW  = 3'd2;

  // Codes 3, 6 and 7 are not legal
  // The memory handles them as full words

endpackage : riscv_pkg

`default_nettype wire

//--- design/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

  // Byte address on the core's data bus
  typedef logic [31:0] addr_t;

  // One enable per byte lane, bit n for lane n
  typedef logic [3:0] byte_en_t;

  // Primary window seen by the core
  localparam addr_t DEFAULT_BASE_ADDR = 32'h0100_0000;

  // Second window onto the same RAM
  localparam addr_t DEFAULT_ALIAS_ADDR = 32'h4000_0000;

  // RAM size in bytes, power of two
  localparam int DEFAULT_MEM_BYTES = 4096;

endpackage : mem_map_pkg

`default_nettype wire

//--- design/addr_window.sv
`default_nettype none
`timescale 1ns/1ps

module addr_window #(
  parameter mem_map_pkg::addr_t BASE_ADDR  = mem_map_pkg::DEFAULT_BASE_ADDR,
  parameter mem_map_pkg::addr_t ALIAS_ADDR = mem_map_pkg::DEFAULT_ALIAS_ADDR,
  parameter int                 MEM_BYTES  = mem_map_pkg::DEFAULT_MEM_BYTES
) (
  input  logic                         clk,
  input  logic                         reset_i,
  input  mem_map_pkg::addr_t           addr_i,
  input  riscv_pkg::funct3_t           funct3_i,
  input  logic                         read_en_i,
  input  logic                         write_en_i,
  output logic [$clog2(MEM_BYTES)-1:0] offset_o,
  output logic                         access_ok_o,
  output logic                         fault_o,
  output logic                         fault_valid_o,
  output mem_map_pkg::addr_t           fault_addr_o
);
  import riscv_pkg::*;
  import mem_map_pkg::*;

  localparam int    OFF_W     = $clog2(MEM_BYTES);
  localparam addr_t WIN_BYTES = addr_t'(MEM_BYTES);

  addr_t base_diff;
  addr_t alias_diff;
  logic  in_base;
  logic  in_alias;
  logic  in_range;
  logic  size_byte;
  logic  size_half;
  logic  aligned;

  // Distance from each window start
  assign base_diff  = addr_i - BASE_ADDR;
  assign alias_diff = addr_i - ALIAS_ADDR;

  // Lower bound checked apart, the difference wraps below the start
  assign in_base  = (addr_i >= BASE_ADDR) && (base_diff < WIN_BYTES);
  assign in_alias = (addr_i >= ALIAS_ADDR) && (alias_diff < WIN_BYTES);

  // Address zero never maps, even with a window at zero
  assign in_range = (addr_i != '0) && (in_base || in_alias);

  // Byte offset into the RAM, base window first
  always_comb begin
    if (in_base) begin
      offset_o = base_diff[OFF_W-1:0];
    end else if (in_alias) begin
      offset_o = alias_diff[OFF_W-1:0];
    end else begin
      offset_o = '0;
    end
  end

  // Access size; store and load codes part ways above 2
  always_comb begin
    size_byte = 1'b0;
    size_half = 1'b0;
    if (write_en_i) begin
      case (funct3_i)
        FUNCT3_SB: size_byte = 1'b1;
        FUNCT3_SH: size_half = 1'b1;
        // SW and unknown codes are words
        default:   size_byte = 1'b0;
      endcase
    end else begin
      case (funct3_i)
        FUNCT3_LB, FUNCT3_LBU: size_byte = 1'b1;
        FUNCT3_LH, FUNCT3_LHU: size_half = 1'b1;
        default:               size_byte = 1'b0;
      endcase
    end
  end

  // Lane RAM cannot span two words
  assign aligned = size_byte
                 | (size_half & ~addr_i[0])
                 | (~size_byte & ~size_half & (addr_i[1:0] == 2'b00));

  assign access_ok_o = in_range && aligned;
  assign fault_o     = (read_en_i || write_en_i) && !access_ok_o;

  // Fault pulse and address for the trap logic
  always_ff @(posedge clk) begin
    if (reset_i) begin
      fault_valid_o <= 1'b0;
      fault_addr_o  <= '0;
    end else begin
      fault_valid_o <= fault_o;
      // Held until the next fault
      if (fault_o) begin
        fault_addr_o <= addr_i;
      end
    end
  end

endmodule : addr_window

`default_nettype wire

//--- design/store_align.sv
`default_nettype none
`timescale 1ns/1ps

module store_align (
  input  riscv_pkg::word_t     wdata_i,
  input  riscv_pkg::funct3_t   funct3_i,
  input  logic [1:0]           byte_off_i,
  output riscv_pkg::word_t     lane_wdata_o,
  output mem_map_pkg::byte_en_t lane_be_o
);
  import riscv_pkg::*;
  import mem_map_pkg::*;

  byte_en_t be_byte;
  byte_en_t be_half;

  // Single lane picked by the byte offset
  assign be_byte = byte_en_t'(4'b0001 << byte_off_i);

  // Halfwords are aligned so only offset bit 1 matters
  assign be_half = byte_off_i[1] ? 4'b1100 : 4'b0011;

  always_comb begin
    case (funct3_i)
      FUNCT3_SB: begin
        // Low byte copied into every lane
        lane_wdata_o = {4{wdata_i[7:0]}};
        lane_be_o    = be_byte;
      end
      FUNCT3_SH: begin
        // Low half copied into both halves
        lane_wdata_o = {2{wdata_i[15:0]}};
        lane_be_o    = be_half;
      end
      default: begin
        // SW and unknown codes store the full word
        lane_wdata_o = wdata_i;
        lane_be_o    = 4'b1111;
      end
    endcase
  end

endmodule : store_align

`default_nettype wire

//--- design/byte_ram.sv
`default_nettype none
`timescale 1ns/1ps

module byte_ram #(
  parameter int MEM_BYTES = mem_map_pkg::DEFAULT_MEM_BYTES
) (
  input  logic                         clk,
  input  logic                         write_en_i,
  input  logic [$clog2(MEM_BYTES)-3:0] word_idx_i,
  input  riscv_pkg::word_t             lane_wdata_i,
  input  mem_map_pkg::byte_en_t        lane_be_i,
  output riscv_pkg::word_t             rd_word_o
);

  // Word index width and entries per lane
  localparam int IDX_W = $clog2(MEM_BYTES) - 2;
  localparam int DEPTH = 2 ** IDX_W;

  // One byte-wide array per lane
  for (genvar lane = 0; lane < 4; lane++) begin : g_lane
    logic [7:0] mem [DEPTH];

    // Write only enabled lanes
    always_ff @(posedge clk) begin
      if (write_en_i && lane_be_i[lane]) begin
        mem[word_idx_i] <= lane_wdata_i[8*lane +: 8];
      end
    end

    // Combinational read, same index for all lanes
    assign rd_word_o[8*lane +: 8] = mem[word_idx_i];
  end

endmodule : byte_ram

`default_nettype wire

//--- design/load_extract.sv
`default_nettype none
`timescale 1ns/1ps

module load_extract (
  input  logic               read_en_i,
  input  riscv_pkg::word_t   rd_word_i,
  input  riscv_pkg::funct3_t funct3_i,
  input  logic [1:0]         byte_off_i,
  output riscv_pkg::word_t   rdata_o
);
  import riscv_pkg::*;

  word_t       shifted;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  word_t       extended;

  // Addressed lane moved down to bit 0
  assign shifted = rd_word_i >> {byte_off_i, 3'b000};
  assign ld_byte = shifted[7:0];
  assign ld_half = shifted[15:0];

  // Extension by funct3
  always_comb begin
    case (funct3_i)
      // Signed byte
      FUNCT3_LB:  extended = {{24{ld_byte[7]}}, ld_byte};
      // Unsigned byte
      FUNCT3_LBU: extended = {24'h0, ld_byte};
      FUNCT3_LH:  extended = {{16{ld_half[15]}}, ld_half};
      FUNCT3_LHU: extended = {16'h0, ld_half};
      // LW and unknown codes read the whole word
      default:    extended = rd_word_i;
    endcase
  end

  // Zero unless a valid load is under way
  assign rdata_o = read_en_i ? extended : '0;

endmodule : load_extract

`default_nettype wire

//--- design/data_mem.sv
`default_nettype none
`timescale 1ns/1ps

module data_mem #(
  parameter mem_map_pkg::addr_t BASE_ADDR  = mem_map_pkg::DEFAULT_BASE_ADDR,
  parameter mem_map_pkg::addr_t ALIAS_ADDR = mem_map_pkg::DEFAULT_ALIAS_ADDR,
  parameter int                 MEM_BYTES  = mem_map_pkg::DEFAULT_MEM_BYTES
) (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               read_en_i,
  input  logic               write_en_i,
  input  mem_map_pkg::addr_t addr_i,
  input  riscv_pkg::word_t   wdata_i,
  input  riscv_pkg::funct3_t funct3_i,
  output riscv_pkg::word_t   rdata_o,
  output logic               fault_o,
  output logic               fault_valid_o,
  output mem_map_pkg::addr_t fault_addr_o
);
  import riscv_pkg::*;
  import mem_map_pkg::*;

  localparam int OFF_W = $clog2(MEM_BYTES);

  logic [OFF_W-1:0] mem_offset;
  logic             access_ok;
  logic             ram_we;
  logic             load_en;
  word_t            lane_wdata;
  byte_en_t         lane_be;
  word_t            rd_word;

  // Faulting accesses never reach the RAM
  assign ram_we  = write_en_i && access_ok;
  assign load_en = read_en_i && access_ok;

  // Window decode, alignment and fault capture
  addr_window #(
    .BASE_ADDR  (BASE_ADDR),
    .ALIAS_ADDR (ALIAS_ADDR),
    .MEM_BYTES  (MEM_BYTES)
  ) u_addr_window (
    .clk           (clk),
    .reset_i       (reset_i),
    .addr_i        (addr_i),
    .funct3_i      (funct3_i),
    .read_en_i     (read_en_i),
    .write_en_i    (write_en_i),
    .offset_o      (mem_offset),
    .access_ok_o   (access_ok),
    .fault_o       (fault_o),
    .fault_valid_o (fault_valid_o),
    .fault_addr_o  (fault_addr_o)
  );

  // Store data onto lanes
  store_align u_store_align (
    .wdata_i      (wdata_i),
    .funct3_i     (funct3_i),
    .byte_off_i   (mem_offset[1:0]),
    .lane_wdata_o (lane_wdata),
    .lane_be_o    (lane_be)
  );

  // Word index drops the byte offset
  byte_ram #(
    .MEM_BYTES (MEM_BYTES)
  ) u_byte_ram (
    .clk          (clk),
    .write_en_i   (ram_we),
    .word_idx_i   (mem_offset[OFF_W-1:2]),
    .lane_wdata_i (lane_wdata),
    .lane_be_i    (lane_be),
    .rd_word_o    (rd_word)
  );

  // Lane select and extension, same cycle as the strobe
  load_extract u_load_extract (
    .read_en_i  (load_en),
    .rd_word_i  (rd_word),
    .funct3_i   (funct3_i),
    .byte_off_i (mem_offset[1:0]),
    .rdata_o    (rdata_o)
  );

endmodule : data_mem

`default_nettype wire

//--- testbench/data_mem_assert.sv
`default_nettype none
`timescale 1ns/1ps

module data_mem_assert (
  input logic               clk,
  input logic               reset_i,
  input logic               read_en_i,
  input logic               write_en_i,
  input mem_map_pkg::addr_t addr_i,
  input riscv_pkg::word_t   rdata_o,
  input logic               fault_o,
  input logic               fault_valid_o,
  input mem_map_pkg::addr_t fault_addr_o
);

  // Read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // A faulting access never returns data
  fault_zero_data: assert property (@(posedge clk) disable iff (reset_i)
    fault_o |-> (rdata_o == '0))
    else begin
      fail_count++;
      $error("rdata_o not zero while fault_o is high");
    end

  // Report one cycle after the strobe, with its address
  fault_capture: assert property (@(posedge clk) disable iff (reset_i)
    fault_o |=> (fault_valid_o && (fault_addr_o == $past(addr_i))))
    else begin
      fail_count++;
      $error("fault_valid_o or fault_addr_o wrong after a fault");
    end

  // No report without a fault before it
  fault_pulse_only: assert property (@(posedge clk) disable iff (reset_i)
    !fault_o |=> !fault_valid_o)
    else begin
      fail_count++;
      $error("fault_valid_o high without a faulting strobe");
    end

  // Held low through reset and the cycle after
  reset_clears: assert property (@(posedge clk) reset_i |=> !fault_valid_o)
    else begin
      fail_count++;
      $error("fault_valid_o high during or right after reset");
    end

  // Core issues one access per cycle
  one_strobe: assert property (@(posedge clk) !(read_en_i && write_en_i))
    else begin
      fail_count++;
      $error("read_en_i and write_en_i high together");
    end

endmodule : data_mem_assert

bind data_mem data_mem_assert u_assert (
  .clk           (clk),
  .reset_i       (reset_i),
  .read_en_i     (read_en_i),
  .write_en_i    (write_en_i),
  .addr_i        (addr_i),
  .rdata_o       (rdata_o),
  .fault_o       (fault_o),
  .fault_valid_o (fault_valid_o),
  .fault_addr_o  (fault_addr_o)
);

`default_nettype wire

//--- testbench/data_mem_tb.sv
`default_nettype none
`timescale 1ns/1ps

module data_mem_tb;
  import riscv_pkg::*;
  import mem_map_pkg::*;

  localparam int    MEM_BYTES  = 4096;
  localparam addr_t BASE       = DEFAULT_BASE_ADDR;
  localparam addr_t ALIAS      = DEFAULT_ALIAS_ADDR;
  localparam int    FAULT_WAIT = 4;
  localparam int    RAND_OPS   = 300;

  logic    clk;
  logic    reset;
  logic    read_en;
  logic    write_en;
  addr_t   addr;
  word_t   wdata;
  funct3_t funct3;
  word_t   rdata;
  logic    fault;
  logic    fault_valid;
  addr_t   fault_addr;

  // Byte-wide reference copy of the RAM
  logic [7:0]  model_mem [MEM_BYTES];
  logic [31:0] lfsr_state;
  int          value_errors;
  int          wait_errors;
  // Address the trap register should hold
  addr_t       last_fault;

  data_mem #(
    .BASE_ADDR  (BASE),
    .ALIAS_ADDR (ALIAS),
    .MEM_BYTES  (MEM_BYTES)
  ) u_dut (
    .clk           (clk),
    .reset_i       (reset),
    .read_en_i     (read_en),
    .write_en_i    (write_en),
    .addr_i        (addr),
    .wdata_i       (wdata),
    .funct3_i      (funct3),
    .rdata_o       (rdata),
    .fault_o       (fault),
    .fault_valid_o (fault_valid),
    .fault_addr_o  (fault_addr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // One step per bit taken
  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Bytes moved by one access
  // Stores 2 to 7 and loads 2, 3, 6, 7 are words
  function automatic int access_size(input funct3_t f, input logic is_write);
    if (f == 3'd0 || (!is_write && f == 3'd4)) begin
      return 1;
    end else if (f == 3'd1 || (!is_write && f == 3'd5)) begin
      return 2;
    end
    return 4;
  endfunction

  // Window hit and alignment; off is the RAM byte offset
  function automatic logic decode_addr(input addr_t a, input funct3_t f,
                                       input logic is_write, output int off);
    logic in_base;
    logic in_alias;
    int   size;
    size     = access_size(f, is_write);
    in_base  = (a >= BASE) && (a < BASE + addr_t'(MEM_BYTES));
    in_alias = (a >= ALIAS) && (a < ALIAS + addr_t'(MEM_BYTES));
    off      = in_base ? int'(a - BASE) : int'(a - ALIAS);
    return (a != '0) && (in_base || in_alias) && ((a & addr_t'(size - 1)) == '0);
  endfunction

  function automatic word_t expected_load(input int off, input funct3_t f);
    int         w;
    logic [7:0] b;
    logic [15:0] h;
    w = off - (off % 4);
    b = model_mem[off];
    case (f)
      FUNCT3_LB:  return {{24{b[7]}}, b};
      FUNCT3_LBU: return {24'h0, b};
      FUNCT3_LH, FUNCT3_LHU: begin
        h = {model_mem[off+1], model_mem[off]};
        return (f == FUNCT3_LH) ? {{16{h[15]}}, h} : {16'h0, h};
      end
      default: return {model_mem[w+3], model_mem[w+2], model_mem[w+1], model_mem[w]};
    endcase
  endfunction

  // Little-endian bytes from the low end of the store data
  task automatic apply_store(input int off, input word_t d, input funct3_t f);
    for (int i = 0; i < access_size(f, 1'b1); i++) begin
      model_mem[off+i] = d[8*i +: 8];
    end
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // One strobe cycle, then one idle cycle for the fault report
  task automatic access(input logic is_write, input addr_t a, input word_t d, input funct3_t f);
    logic  ok;
    int    off;
    int    waited;
    word_t exp;
    ok  = decode_addr(a, f, is_write, off);
    exp = (!is_write && ok) ? expected_load(off, f) : '0;
    @(posedge clk);
    read_en  <= !is_write;
    write_en <= is_write;
    addr     <= a;
    wdata    <= d;
    funct3   <= f;
    @(negedge clk);
    compare("fault_o", 32'(fault), 32'(!ok));
    // Previous fault address still held
    compare("fault_addr_o", fault_addr, last_fault);
    if (!is_write) begin
      compare("rdata_o", rdata, exp);
    end
    @(posedge clk);
    read_en  <= 1'b0;
    write_en <= 1'b0;
    if (is_write && ok) begin
      apply_store(off, d, f);
    end
    if (!ok) begin
      waited = 0;
      @(negedge clk);
      while (!fault_valid && waited < FAULT_WAIT) begin
        @(negedge clk);
        waited++;
      end
      if (fault_valid !== 1'b1) begin
        wait_errors++;
        $display("Timed out waiting for the fault report of address %h", a);
      end else begin
        compare("fault_valid_o delay", 32'(waited), 32'd0);
        compare("fault_addr_o", fault_addr, a);
      end
      last_fault = a;
    end
  endtask

  initial begin
    logic  is_write;
    addr_t a;
    word_t d;
    funct3_t f;
    logic [1:0] sel;
    int    assert_errors;
    lfsr_state   = 32'h57ce6f52;
    value_errors = 0;
    wait_errors  = 0;
    last_fault   = '0;
    reset    <= 1'b1;
    // Faulting load while in reset, never reported
    read_en  <= 1'b1;
    write_en <= 1'b0;
    addr     <= 32'h0000_0010;
    wdata    <= '0;
    funct3   <= FUNCT3_LW;
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      if (i == 7) begin
        read_en <= 1'b0;
      end
    end
    reset <= 1'b0;

    // Whole RAM written with a pattern from the full offset
    for (int i = 0; i < MEM_BYTES; i += 4) begin
      access(1'b1, BASE + addr_t'(i), {i[15:0] ^ 16'ha5c3, ~i[15:0]}, FUNCT3_SW);
    end

    // Word round trip through both windows
    access(1'b1, BASE + 32'h100, 32'hdead_beef, FUNCT3_SW);
    access(1'b0, BASE + 32'h100, '0, FUNCT3_LW);
    access(1'b0, ALIAS + 32'h100, '0, FUNCT3_LW);
    access(1'b1, ALIAS + 32'h104, 32'h0bad_cafe, FUNCT3_SW);
    access(1'b0, BASE + 32'h104, '0, FUNCT3_LW);

    // Partial stores, then every legal load offset
    access(1'b1, BASE + 32'h200, 32'h807f_ff01, FUNCT3_SW);
    access(1'b1, BASE + 32'h204, 32'h1234_5678, FUNCT3_SW);
    access(1'b1, BASE + 32'h201, 32'h0000_00a5, FUNCT3_SB);
    access(1'b1, BASE + 32'h206, 32'hffff_8123, FUNCT3_SH);
    for (int i = 0; i < 8; i++) begin
      access(1'b0, BASE + 32'h200 + addr_t'(i), '0, FUNCT3_LB);
      access(1'b0, BASE + 32'h200 + addr_t'(i), '0, FUNCT3_LBU);
      if (i % 2 == 0) begin
        access(1'b0, BASE + 32'h200 + addr_t'(i), '0, FUNCT3_LH);
        access(1'b0, BASE + 32'h200 + addr_t'(i), '0, FUNCT3_LHU);
      end
      if (i % 4 == 0) begin
        access(1'b0, BASE + 32'h200 + addr_t'(i), '0, FUNCT3_LW);
      end
    end

    // Out of range and misaligned
    access(1'b0, 32'h0, '0, FUNCT3_LW);
    access(1'b1, 32'h0, 32'hffff_ffff, FUNCT3_SW);
    access(1'b0, BASE - 32'd4, '0, FUNCT3_LW);
    access(1'b1, BASE + 32'd4096, 32'h1111_1111, FUNCT3_SW);
    access(1'b0, ALIAS + 32'd4096, '0, FUNCT3_LB);
    access(1'b1, ALIAS - 32'd1, 32'h0000_0022, FUNCT3_SB);
    access(1'b0, BASE + 32'h301, '0, FUNCT3_LH);
    access(1'b1, BASE + 32'h303, 32'h0000_3333, FUNCT3_SH);
    access(1'b0, BASE + 32'h302, '0, FUNCT3_LW);
    access(1'b1, BASE + 32'h305, 32'h4444_4444, FUNCT3_SW);
    // Dropped stores left no trace
    access(1'b0, BASE, '0, FUNCT3_LW);
    access(1'b0, BASE + 32'h300, '0, FUNCT3_LW);
    access(1'b0, BASE + 32'h304, '0, FUNCT3_LW);
    access(1'b0, ALIAS + 32'hffc, '0, FUNCT3_LW);

    // Illegal codes act as words
    access(1'b1, BASE + 32'h400, 32'hcafe_f00d, 3'd3);
    access(1'b0, BASE + 32'h400, '0, 3'd3);
    access(1'b0, BASE + 32'h400, '0, 3'd6);
    access(1'b0, ALIAS + 32'h400, '0, 3'd7);
    access(1'b0, BASE + 32'h402, '0, 3'd6);

    // Mixed traffic, windows, edges and stray addresses
    for (int n = 0; n < RAND_OPS; n++) begin
      is_write = take_bits(1);
      f        = take_bits(3);
      d        = take_bits(32);
      sel      = take_bits(2);
      case (sel)
        2'd0:    a = BASE + take_bits(12);
        2'd1:    a = ALIAS + take_bits(12);
        2'd2:    a = BASE + 32'd4088 + take_bits(4);
        default: a = take_bits(32);
      endcase
      if (take_bits(1)) begin
        a[1:0] = 2'b00;
      end
      access(is_write, a, d, f);
    end

    @(posedge clk);
    @(posedge clk);
    assert_errors = int'(u_dut.u_assert.fail_count);
    $display("Errors: %0d value, %0d timeout, %0d assertion",
             value_errors, wait_errors, assert_errors);
    if (value_errors == 0 && wait_errors == 0 && assert_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : data_mem_tb

`default_nettype wire

//--- data_mem.f
design/riscv_pkg.sv
design/mem_map_pkg.sv
design/addr_window.sv
design/store_align.sv
design/byte_ram.sv
design/load_extract.sv
design/data_mem.sv
testbench/data_mem_assert.sv
testbench/data_mem_tb.sv

//--- Bender.yml
package:
  name: data_mem

sources:
  - design/riscv_pkg.sv
  - design/mem_map_pkg.sv
  - design/addr_window.sv
  - design/store_align.sv
  - design/byte_ram.sv
  - design/load_extract.sv
  - design/data_mem.sv
  - target: test
    files:
      - testbench/data_mem_assert.sv
      - testbench/data_mem_tb.sv
